/* source/halfAccum_settings.svh */
`ifndef HALFACCUM_SETTINGS_SVH
`define HALFACCUM_SETTINGS_SVH

// IEEE 754 binary16 layout
`define HF_EXP_BITS 5
`define HF_MANT_BITS 10
`define HF_WIDTH 16
`define HF_BIAS 15

// Guard, round and sticky kept below the mantissa LSB
`define HF_GRS_BITS 3

// Run length and memory port
`define ACCUM_COUNT 16
`define ACCUM_ADDR_BITS 4

// One register per adder stage
`define HF_ADD_LATENCY 3

`endif

/* source/halfAccumPkg.sv */
`include "halfAccum_settings.svh"

package halfAccumPkg;

	// Half-precision word, sign on top
	typedef struct packed {
		logic sign;
		logic [`HF_EXP_BITS-1:0] expo; // Biased exponent
		logic [`HF_MANT_BITS-1:0] mant; // Stored fraction, hidden one implied
	} halfT;

	// Working mantissa inside the adder
	// [14] carry, [13] hidden one, [12:3] fraction, [2:0] guard/round/sticky
	typedef logic [`HF_MANT_BITS+`HF_GRS_BITS+1:0] mantGrsT;

	// Controller FSM
	typedef enum logic [2:0] {
		Idle,
		Fetch, // Memory read issued
		Load, // Word on memQ, handed to adder
		AddWait, // Waiting for adder result
		Finish // Done/ready pulse
	} accumStateT;

endpackage

/* source/hfStageIf.sv */
`timescale 1ns/1ps
`include "halfAccum_settings.svh"

// Align stage to add stage
interface alignLinkIf import halfAccumPkg::*; ();
	logic valid;
	logic sign; // Sign of the larger operand
	logic [`HF_EXP_BITS-1:0] expo; // Common exponent
	mantGrsT largeMant;
	mantGrsT smallMant; // Already shifted, sticky folded in
	logic effSub; // Operand signs differ

	modport producer (output valid, sign, expo, largeMant, smallMant, effSub);
	modport consumer (input valid, sign, expo, largeMant, smallMant, effSub);
endinterface

// Add stage to normalize/round stage
interface sumLinkIf import halfAccumPkg::*; ();
	logic valid;
	logic sign;
	logic [`HF_EXP_BITS-1:0] expo;
	mantGrsT rawSum; // Unnormalized, may carry into top bit

	modport producer (output valid, sign, expo, rawSum);
	modport consumer (input valid, sign, expo, rawSum);
endinterface

/* source/hfAlignStage.sv */
`timescale 1ns/1ps
`include "halfAccum_settings.svh"

module hfAlignStage import halfAccumPkg::*; (
	input logic ap_clk,
	input logic ap_rst,
	input logic inVld,
	input halfT opA,
	input halfT opB,
	alignLinkIf.producer alignOut
);
	localparam int MgW = $bits(mantGrsT);

	logic swap; // B has the larger magnitude
	halfT opBig;
	halfT opSmall;
	logic [`HF_EXP_BITS-1:0] expDiff;
	mantGrsT bigMant;
	mantGrsT smallExt;
	mantGrsT smallAligned;
	logic [2*MgW-1:0] shiftWide; // Upper half kept, lower half becomes sticky

	// Exponent and fraction compare as one unsigned field
	assign swap = {opB.expo, opB.mant} > {opA.expo, opA.mant};
	assign opBig = swap ? opB : opA;
	assign opSmall = swap ? opA : opB;
	assign expDiff = opBig.expo - opSmall.expo; // Never negative

	// Hidden one only for a nonzero exponent
	assign bigMant = {1'b0, |opBig.expo, opBig.mant, {`HF_GRS_BITS{1'b0}}};
	assign smallExt = {1'b0, |opSmall.expo, opSmall.mant, {`HF_GRS_BITS{1'b0}}};

	assign shiftWide = {smallExt, {MgW{1'b0}}} >> expDiff;

	always_comb begin
		if (expDiff >= MgW) begin
			// Everything shifted out, only sticky remains
			smallAligned = {{(MgW-1){1'b0}}, |smallExt};
		end else begin
			smallAligned = shiftWide[2*MgW-1 -: MgW] |
				{{(MgW-1){1'b0}}, |shiftWide[MgW-1:0]};
		end
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			alignOut.valid <= 1'b0;
		end else begin
			alignOut.valid <= inVld;
		end
	end

	always_ff @(posedge ap_clk) begin
		alignOut.sign <= opBig.sign; // Result takes sign of larger magnitude
		alignOut.expo <= opBig.expo;
		alignOut.largeMant <= bigMant;
		alignOut.smallMant <= smallAligned;
		alignOut.effSub <= opA.sign ^ opB.sign;
	end

	// Pipeline valid must be clean once out of reset
	validKnown: assert property (@(posedge ap_clk) disable iff (ap_rst)
		!$isunknown(alignOut.valid));

endmodule

/* source/hfAddStage.sv */
`timescale 1ns/1ps

module hfAddStage import halfAccumPkg::*; (
	input logic ap_clk,
	input logic ap_rst,
	alignLinkIf.consumer alignIn,
	sumLinkIf.producer sumOut
);
	mantGrsT rawSum;
	logic cancelZero;

	// Larger magnitude is always on the left, so no borrow out
	always_comb begin
		if (alignIn.effSub) begin
			rawSum = alignIn.largeMant - alignIn.smallMant;
		end else begin
			rawSum = alignIn.largeMant + alignIn.smallMant; // Top bit catches carry
		end
	end

	// Exact cancellation of opposite signs
	assign cancelZero = alignIn.effSub && (rawSum == '0);

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			sumOut.valid <= 1'b0;
		end else begin
			sumOut.valid <= alignIn.valid;
		end
	end

	always_ff @(posedge ap_clk) begin
		sumOut.sign <= cancelZero ? 1'b0 : alignIn.sign; // x + (-x) is +0
		sumOut.expo <= alignIn.expo;
		sumOut.rawSum <= rawSum;
	end

endmodule

/* source/hfNormRoundStage.sv */
`timescale 1ns/1ps
`include "halfAccum_settings.svh"

module hfNormRoundStage import halfAccumPkg::*; (
	input logic ap_clk,
	input logic ap_rst,
	sumLinkIf.consumer sumIn,
	output logic sumVld,
	output halfT sum
);
	localparam int MgW = $bits(mantGrsT);
	localparam int HidPos = `HF_MANT_BITS + `HF_GRS_BITS; // Hidden one position
	localparam int LzW = $clog2(MgW);
	localparam int ExpW = `HF_EXP_BITS + 2; // Signed, room for over/underflow
	localparam int ExpMax = (1 << `HF_EXP_BITS) - 1; // All ones means infinity

	logic [LzW-1:0] lzCount;
	mantGrsT normMant;
	logic signed [ExpW-1:0] normExp;
	logic signed [ExpW-1:0] finalExp;
	logic roundUp;
	logic [`HF_MANT_BITS+1:0] rounded; // Hidden one, fraction, rounding carry
	logic [`HF_MANT_BITS-1:0] roundedMant;
	halfT resWord;

	// Leading-one detect, highest set bit wins
	always_comb begin
		lzCount = '0;
		for (int i = 0; i <= HidPos; i++) begin
			if (sumIn.rawSum[i]) begin
				lzCount = LzW'(HidPos - i);
			end
		end
	end

	always_comb begin
		if (sumIn.rawSum[MgW-1]) begin
			// Carry out, one right shift, dropped bit joins sticky
			normMant = {1'b0, sumIn.rawSum[MgW-1:2], sumIn.rawSum[1] | sumIn.rawSum[0]};
			normExp = $signed({2'b00, sumIn.expo}) + ExpW'(1);
		end else begin
			normMant = sumIn.rawSum << lzCount; // Only after near cancellation, GRS exact
			normExp = $signed({2'b00, sumIn.expo}) - $signed({{(ExpW-LzW){1'b0}}, lzCount});
		end
	end

	// Nearest even: guard set and (round, sticky or odd LSB)
	assign roundUp = normMant[2] & (normMant[1] | normMant[0] | normMant[`HF_GRS_BITS]);
	assign rounded = {1'b0, normMant[HidPos:`HF_GRS_BITS]} +
		{{(`HF_MANT_BITS+1){1'b0}}, roundUp};
	assign roundedMant = rounded[`HF_MANT_BITS+1] ? rounded[`HF_MANT_BITS:1]
		: rounded[`HF_MANT_BITS-1:0];
	assign finalExp = normExp + $signed({{(ExpW-1){1'b0}}, rounded[`HF_MANT_BITS+1]});

	always_comb begin
		resWord.sign = sumIn.sign;
		resWord.expo = finalExp[`HF_EXP_BITS-1:0];
		resWord.mant = roundedMant;
		if (sumIn.rawSum == '0) begin
			resWord.expo = '0; // Exact zero keeps its sign
			resWord.mant = '0;
		end else if (finalExp <= 0) begin
			resWord = '0; // Underflow flushes to +0
		end else if (finalExp >= ExpMax) begin
			resWord.expo = '1; // Saturate to infinity
			resWord.mant = '0;
		end
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			sumVld <= 1'b0;
		end else begin
			sumVld <= sumIn.valid;
		end
	end

	always_ff @(posedge ap_clk) begin
		sum <= resWord;
	end

endmodule

/* source/hfAdder.sv */
`timescale 1ns/1ps
`include "halfAccum_settings.svh"

module hfAdder import halfAccumPkg::*; (
	input logic ap_clk,
	input logic ap_rst,
	input logic inVld,
	input halfT opA,
	input halfT opB,
	output logic sumVld,
	output halfT sum
);
	alignLinkIf alignLink ();
	sumLinkIf sumLink ();

	// Stage 1, operand order and alignment
	hfAlignStage align_i (
		.ap_clk (ap_clk),
		.ap_rst (ap_rst),
		.inVld (inVld),
		.opA (opA),
		.opB (opB),
		.alignOut (alignLink.producer)
	);

	// Stage 2, mantissa add/sub
	hfAddStage add_i (
		.ap_clk (ap_clk),
		.ap_rst (ap_rst),
		.alignIn (alignLink.consumer),
		.sumOut (sumLink.producer)
	);

	// Stage 3, normalize and round
	hfNormRoundStage norm_i (
		.ap_clk (ap_clk),
		.ap_rst (ap_rst),
		.sumIn (sumLink.consumer),
		.sumVld (sumVld),
		.sum (sum)
	);

	// Fixed latency through all three stages
	latencyCheck: assert property (@(posedge ap_clk) disable iff (ap_rst)
		inVld |-> ##(`HF_ADD_LATENCY) sumVld);

endmodule

/* source/accumControl.sv */
`timescale 1ns/1ps
`include "halfAccum_settings.svh"

module accumControl import halfAccumPkg::*; (
	input logic ap_clk,
	input logic ap_rst,
	input logic apStart,
	input logic apContinue,
	output logic apDone,
	output logic apIdle,
	output logic apReady,
	output logic [`ACCUM_ADDR_BITS-1:0] memAddr,
	output logic memCe,
	input halfT memQ,
	output logic addVld,
	output halfT addA,
	output halfT addB,
	input logic sumVld,
	input halfT sum,
	output halfT result,
	output logic resultVld
);
	localparam int IdxW = `ACCUM_ADDR_BITS + 1; // One extra bit to reach ACCUM_COUNT
	localparam logic [IdxW-1:0] LastIdx = IdxW'(`ACCUM_COUNT - 1);

	accumStateT state;
	accumStateT nextState;
	logic [IdxW-1:0] wordIdx;
	logic doneReg; // Held done, waits for apContinue
	logic startOk;
	logic sumTake; // Adder result captured this cycle
	halfT runSum;
	halfT resultReg;

	assign startOk = (state == Idle) && apStart && !doneReg;
	assign sumTake = (state == AddWait) && sumVld;

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (startOk) begin
					nextState = Fetch;
				end
			end
			Fetch: nextState = Load;
			Load: nextState = AddWait;
			AddWait: begin
				if (sumTake) begin
					nextState = (wordIdx == LastIdx) ? Finish : Fetch;
				end
			end
			Finish: nextState = Idle;
			default: nextState = Idle;
		endcase
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= Idle;
			wordIdx <= '0;
			doneReg <= 1'b0;
		end else begin
			state <= nextState;
			if (startOk) begin
				wordIdx <= '0;
			end else if (sumTake) begin
				wordIdx <= wordIdx + 1'b1;
			end
			if (apContinue) begin
				doneReg <= 1'b0; // Continue wins over a new done
			end else if (state == Finish) begin
				doneReg <= 1'b1;
			end
		end
	end

	// Running sum and last published result
	always_ff @(posedge ap_clk) begin
		if (startOk) begin
			runSum <= '0;
		end else if (sumTake) begin
			runSum <= sum;
		end
		if (state == Finish) begin
			resultReg <= runSum;
		end
	end

	assign memCe = (state == Fetch);
	assign memAddr = wordIdx[`ACCUM_ADDR_BITS-1:0];
	assign addVld = (state == Load); // memQ valid one cycle after Fetch
	assign addA = runSum;
	assign addB = memQ;

	assign apDone = (state == Finish) || doneReg;
	assign apReady = (state == Finish);
	assign apIdle = (state == Idle) && !apStart;
	assign resultVld = (state == Finish);
	assign result = (state == Finish) ? runSum : resultReg;

	// Adder result only lands while the FSM waits for it
	sumInWait: assert property (@(posedge ap_clk) disable iff (ap_rst)
		sumVld |-> (state == AddWait));

	idxRange: assert property (@(posedge ap_clk) disable iff (ap_rst)
		wordIdx <= IdxW'(`ACCUM_COUNT));

endmodule

/* source/halfAccumTop.sv */
`timescale 1ns/1ps
`include "halfAccum_settings.svh"

module halfAccumTop import halfAccumPkg::*; (
	input logic ap_clk,
	input logic ap_rst,
	input logic apStart,
	input logic apContinue,
	output logic apDone,
	output logic apIdle,
	output logic apReady,
	output logic [`ACCUM_ADDR_BITS-1:0] memAddr,
	output logic memCe,
	input logic [`HF_WIDTH-1:0] memQ,
	output logic [`HF_WIDTH-1:0] result,
	output logic resultVld
);
	logic addVld;
	halfT addA; // Running sum
	halfT addB; // Memory word
	logic sumVld;
	halfT sum;

	accumControl ctrl_i (
		.ap_clk (ap_clk),
		.ap_rst (ap_rst),
		.apStart (apStart),
		.apContinue (apContinue),
		.apDone (apDone),
		.apIdle (apIdle),
		.apReady (apReady),
		.memAddr (memAddr),
		.memCe (memCe),
		.memQ (memQ),
		.addVld (addVld),
		.addA (addA),
		.addB (addB),
		.sumVld (sumVld),
		.sum (sum),
		.result (result),
		.resultVld (resultVld)
	);

	hfAdder adder_i (
		.ap_clk (ap_clk),
		.ap_rst (ap_rst),
		.inVld (addVld),
		.opA (addA),
		.opB (addB),
		.sumVld (sumVld),
		.sum (sum)
	);

endmodule

/* sim/halfAccumTb.sv */
`timescale 1ns/1ps
`include "halfAccum_settings.svh"

module halfAccumTb;
	localparam int FixedRows = 6;
	localparam int RandRows = 8;
	localparam int NumRows = FixedRows + RandRows;
	// Per run plus handshake slack
	localparam int CycleLimit = NumRows * (`ACCUM_COUNT * 5 + 10) + 400;

	// Hand-picked rows, half-precision words in read order
	localparam logic [15:0] FixedWords [FixedRows][`ACCUM_COUNT] = '{
		'{16'h3C00, 16'h4000, 16'h4200, 16'h4400, 16'h4500, 16'h4600, 16'h4700, 16'h4800,
			16'h4880, 16'h4900, 16'h4980, 16'h4A00, 16'h4A80, 16'h4B00, 16'h4B80, 16'h4C00},
		'{16'h3800, 16'h3400, 16'h3A00, 16'h3E00, 16'h3000, 16'h3800, 16'h3400, 16'h3A00,
			16'h3E00, 16'h3000, 16'h3C00, 16'h3800, 16'h3400, 16'h3200, 16'h3A00, 16'h3E00},
		'{16'h6800, 16'h3C00, 16'h3C00, 16'h3C00, 16'h4200, 16'h3C00, 16'h4200, 16'h3C00,
			16'h3C00, 16'h4200, 16'h3C00, 16'h3C00, 16'h3C00, 16'h4200, 16'h3C00, 16'h3C00},
		'{16'h6400, 16'h3801, 16'h37FF, 16'h3801, 16'h3801, 16'h37FF, 16'h3A01, 16'h3401,
			16'h35FF, 16'h3801, 16'h37FF, 16'h3C01, 16'h3801, 16'h3801, 16'h37FF, 16'h3801},
		'{16'h3C00, 16'h4000, 16'h4200, 16'h4400, 16'h4500, 16'h4600, 16'h4700, 16'h4800,
			16'hC800, 16'hC700, 16'hC600, 16'hC500, 16'hC400, 16'hC200, 16'hC000, 16'hBC00},
		'{16'h5640, 16'hB800, 16'h2E66, 16'hC500, 16'h3555, 16'h4900, 16'h2C00, 16'hD140,
			16'h3C01, 16'h1800, 16'hBA00, 16'h4D00, 16'hA400, 16'h5000, 16'hC880, 16'h3266}
	};

	logic ap_clk;
	logic ap_rst;
	logic apStart;
	logic apContinue;
	logic apDone;
	logic apIdle;
	logic apReady;
	logic [`ACCUM_ADDR_BITS-1:0] memAddr;
	logic memCe;
	logic [15:0] memQ = '0;
	logic [15:0] result;
	logic resultVld;

	string rowName [NumRows];
	logic [15:0] rowWords [NumRows][`ACCUM_COUNT];
	logic [15:0] memArray [`ACCUM_COUNT]; // Loaded per run
	int curRow = 0;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int readCount = 0; // memCe cycles since reset
	int readyCount = 0;
	int vldCount = 0;
	logic [15:0] capturedResult = '0; // result seen with resultVld

	halfAccumTop dut_i (
		.ap_clk (ap_clk),
		.ap_rst (ap_rst),
		.apStart (apStart),
		.apContinue (apContinue),
		.apDone (apDone),
		.apIdle (apIdle),
		.apReady (apReady),
		.memAddr (memAddr),
		.memCe (memCe),
		.memQ (memQ),
		.result (result),
		.resultVld (resultVld)
	);

	initial ap_clk = 1'b0;
	always #4 ap_clk = ~ap_clk; // 8 ns period

	// Synchronous read, data one cycle after memCe
	always @(posedge ap_clk) begin
		if (memCe) begin
			memQ <= memArray[memAddr];
		end
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// Read order and pulse counts, sampled mid-cycle
	always @(negedge ap_clk) begin
		if (!ap_rst) begin
			if (memCe) begin
				checkValue($sformatf("%s memAddr", rowName[curRow]),
					readCount % `ACCUM_COUNT, memAddr);
				readCount++;
			end
			if (apReady) readyCount++;
			if (resultVld) begin
				vldCount++;
				capturedResult = result;
			end
		end
	end

	always @(posedge ap_clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("ERROR: timeout, the DUT did not finish all runs within %0d cycles",
				CycleLimit);
			$display("Checks: %0d, errors: %0d", checkCount, errorCount + 1);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic real pow2(input int n);
		real p;
		p = 1.0;
		for (int i = 0; i < n; i++) p = p * 2.0;
		for (int i = 0; i > n; i--) p = p / 2.0;
		return p;
	endfunction

	function automatic real halfToReal(input logic [15:0] h);
		real mag;
		if (h[14:10] == 5'd0) return 0.0; // Zero only, no subnormals in the tables
		mag = (1.0 + h[9:0] / 1024.0) * pow2(int'(h[14:10]) - 15);
		return h[15] ? -mag : mag;
	endfunction

	// Exact real to half, nearest even, saturate high, flush low to +0
	function automatic logic [15:0] roundToHalf(input real x);
		logic sgn;
		real mag;
		real scaled;
		real frac;
		int e;
		int m;
		int biased;
		sgn = (x < 0.0);
		mag = sgn ? -x : x;
		if (mag == 0.0) return 16'h0000; // Exact cancellation is +0
		e = 0;
		while (mag >= pow2(e + 1)) e++;
		while (mag < pow2(e)) e--;
		scaled = mag * pow2(10 - e); // Now in [1024, 2048)
		m = $rtoi(scaled);
		frac = scaled - m;
		if (frac > 0.5 || (frac == 0.5 && m[0])) m++;
		if (m == 2048) begin
			m = 1024; // Rounding carried into next binade
			e++;
		end
		biased = e + 15;
		if (biased <= 0) return 16'h0000;
		if (biased >= 31) return {sgn, 5'h1F, 10'h000};
		return {sgn, biased[4:0], m[9:0]};
	endfunction

	// Sequential sum, one rounding per addition
	function automatic logic [15:0] referenceSum(input int row);
		logic [15:0] acc;
		acc = 16'h0000;
		for (int i = 0; i < `ACCUM_COUNT; i++) begin
			acc = roundToHalf(halfToReal(acc) + halfToReal(rowWords[row][i]));
		end
		return acc;
	endfunction

	task automatic buildTable();
		logic [31:0] seed;
		logic [15:0] word;
		seed = 32'd99542;
		rowName[0] = "smallInts";
		rowName[1] = "fractions";
		rowName[2] = "tiesToEven";
		rowName[3] = "sticky";
		rowName[4] = "cancelExact";
		rowName[5] = "mixedSigns";
		for (int r = 0; r < FixedRows; r++) begin
			for (int i = 0; i < `ACCUM_COUNT; i++) rowWords[r][i] = FixedWords[r][i];
		end
		for (int r = FixedRows; r < NumRows; r++) begin
			rowName[r] = $sformatf("random%0d", r - FixedRows);
			for (int i = 0; i < `ACCUM_COUNT; i++) begin
				seed = lcgNext(seed);
				word[15] = seed[31];
				word[14:10] = 5'(10 + seed[23:16] % 11); // Exponent 10..20
				word[9:0] = seed[13:4];
				rowWords[r][i] = word;
			end
		end
	endtask

	// One full run, then done held against a stray start
	task automatic runRow(input int row);
		logic [15:0] expected;
		int runs;
		for (int i = 0; i < `ACCUM_COUNT; i++) memArray[i] = rowWords[row][i];
		expected = referenceSum(row);
		curRow = row;
		runs = row + 1;
		@(posedge ap_clk);
		apStart <= 1'b1;
		@(posedge ap_clk);
		apStart <= 1'b0;
		do @(negedge ap_clk); while (!apDone); // Finish cycle
		@(negedge ap_clk);
		checkValue($sformatf("%s sum at resultVld", rowName[row]), expected, capturedResult);
		checkValue($sformatf("%s result held", rowName[row]), expected, result);
		checkValue($sformatf("%s read count", rowName[row]), runs * `ACCUM_COUNT, readCount);
		checkValue($sformatf("%s apReady pulses", rowName[row]), runs, readyCount);
		checkValue($sformatf("%s resultVld pulses", rowName[row]), runs, vldCount);
		@(posedge ap_clk);
		apStart <= 1'b1; // Must be ignored while done held
		@(posedge ap_clk);
		apStart <= 1'b0;
		repeat (3) @(negedge ap_clk);
		checkValue($sformatf("%s apDone held", rowName[row]), 1, apDone);
		checkValue($sformatf("%s no reads while done", rowName[row]),
			runs * `ACCUM_COUNT, readCount);
		@(posedge ap_clk);
		apContinue <= 1'b1;
		@(posedge ap_clk);
		apContinue <= 1'b0;
		@(negedge ap_clk);
		checkValue($sformatf("%s apDone cleared", rowName[row]), 0, apDone);
		checkValue($sformatf("%s apIdle after continue", rowName[row]), 1, apIdle);
	endtask

	initial begin
		ap_rst = 1'b1;
		apStart = 1'b0;
		apContinue = 1'b0;
		buildTable();
		repeat (3) @(posedge ap_clk);
		ap_rst <= 1'b0;
		@(negedge ap_clk);
		checkValue("reset apIdle", 1, apIdle);
		checkValue("reset apDone", 0, apDone);
		checkValue("reset apReady", 0, apReady);
		checkValue("reset resultVld", 0, resultVld);
		checkValue("reset memCe", 0, memCe);
		for (int row = 0; row < NumRows; row++) begin
			runRow(row);
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+source
source/halfAccumPkg.sv
source/hfStageIf.sv
source/hfAlignStage.sv
source/hfAddStage.sv
source/hfNormRoundStage.sv
source/hfAdder.sv
source/accumControl.sv
source/halfAccumTop.sv
sim/halfAccumTb.sv

/* run.sh */
#!/bin/sh
# Build and run the half-precision accumulator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module halfAccumTb -f sources.f -o halfAccumSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/halfAccumSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -qx "Test passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
